// File: verilog/conv_out_pkg.sv
`default_nettype none

package conv_out_pkg;

    ////////////////////////////////////////////////////
    // vector types
    ////////////////////////////////////////////////////

    // output indices, tile starts and tile extents
    typedef logic [15:0] idx_t;

    // power-of-two exponents and quantization shift
    typedef logic [3:0] log2_t;

    // fifo grid coordinates, oy group and of group
    typedef logic [3:0] grid_t;

    typedef logic signed [7:0] pixel_t;
    typedef logic signed [15:0] psum_t;

    ////////////////////////////////////////////////////
    // mode and grid constants
    ////////////////////////////////////////////////////

    // channels per fifo group
    localparam int MODE0_CHANNELS = 16;
    localparam int MODE1_CHANNELS = 32;

    // 4 x 3 grid of arrays, one row fifo per array
    localparam int SA_ROW_NUM = 4;
    localparam int SA_COLUMN_NUM = 3;
    localparam int FIFO_NUM = SA_ROW_NUM * SA_COLUMN_NUM;

endpackage

`default_nettype wire

// File: verilog/row_fifo.sv
`default_nettype none
`timescale 1ns/100ps

module row_fifo #(
    parameter int column_num = 4,
    parameter int fifo_depth = 16
) (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       wr_en,
    input  wire [32*column_num-1:0]   wr_data,
    input  wire                       rd_en,
    output logic [32*column_num-1:0]  rd_data,
    output logic                      empty
);

    localparam int row_width = 32 * column_num;
    localparam int ptr_width = $clog2(fifo_depth);

    logic [row_width-1:0] mem [fifo_depth];
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [ptr_width:0]   count;

    assign empty = (count == '0);

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == ptr_width'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == ptr_width'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // read data held until the next read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// File: verilog/row_quantizer.sv
`default_nettype none
`timescale 1ns/100ps

module row_quantizer
    import conv_out_pkg::*;
#(
    parameter int column_num = 4
) (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       quantify_en,
    input  wire [64*column_num-1:0]   psum_row,
    input  wire log2_t                quant_shift,
    input  wire [3:0]                 fifo_sel,
    output logic [FIFO_NUM-1:0]       wr_en,
    output logic [32*column_num-1:0]  wr_data
);

    localparam int lane_num = 4 * column_num;

    logic [32*column_num-1:0] q_row;
    logic [FIFO_NUM-1:0]      sel_onehot;

    // arithmetic shift, then clamp to the pixel range
    function automatic pixel_t saturate(input psum_t value, input log2_t shift);
        psum_t shifted;
        shifted = value >>> shift;
        if (shifted > 16'sd127) begin
            return 8'sd127;
        end else if (shifted < -16'sd128) begin
            return -8'sd128;
        end
        return shifted[7:0];
    endfunction

    // lane 0 sits in the low bits
    always_comb begin
        for (int i = 0; i < lane_num; i++) begin
            q_row[8*i +: 8] = saturate(psum_row[16*i +: 16], quant_shift);
        end
    end

    always_comb begin
        for (int i = 0; i < FIFO_NUM; i++) begin
            sel_onehot[i] = (fifo_sel == i);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_en <= '0;
        end else begin
            wr_en <= quantify_en ? sel_onehot : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (quantify_en) begin
            wr_data <= q_row;
        end
    end

endmodule

`default_nettype wire

// File: verilog/conv_out_handler.sv
`default_nettype none
`timescale 1ns/100ps

module conv_out_handler
    import conv_out_pkg::*;
#(
    parameter int column_num = 4
) (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       mode,
    input  wire idx_t                 cur_ox_start,
    input  wire idx_t                 cur_oy_start,
    input  wire idx_t                 cur_of_start,
    input  wire idx_t                 cur_pof,
    input  wire idx_t                 cur_poy,
    input  wire                       quantify_add_end,
    // cycle 0
    output logic [FIFO_NUM-1:0]       fifo_rds,
    // cycle 1
    input  wire [32*column_num-1:0]   fifo_data,
    output grid_t                     fifo_column_no,
    output grid_t                     fifo_row_no,
    output logic                      valid_rowi_out_buf_adr,
    output idx_t                      out_y_idx,
    output idx_t                      out_x_idx,
    output idx_t                      out_f_idx,
    output logic [16*column_num-1:0]  out_data,
    output logic                      conv_out_add_end
);

    localparam int row_width = 32 * column_num;
    localparam int out_width = 16 * column_num;

    logic  signal_add;
    idx_t  channel_counter;
    idx_t  of_counter;
    idx_t  oy_counter;
    logic  out_upper;

    idx_t  channel_num;
    log2_t log_channel_num;
    idx_t  of_base;
    idx_t  ch_total;
    idx_t  of_group;
    idx_t  oy_group;
    logic  ch_step;
    logic  ch_last;
    logic  of_last;
    logic  oy_last;
    logic  rd_strobe;

    logic [out_width-1:0] lo_half;
    logic [out_width-1:0] hi_half;

    //////////////////////////////////////////////////
    // loop control
    //////////////////////////////////////////////////

    always_comb begin
        if (mode == 1'b0) begin
            channel_num     = idx_t'(MODE0_CHANNELS);
            log_channel_num = log2_t'($clog2(MODE0_CHANNELS));
        end else begin
            channel_num     = idx_t'(MODE1_CHANNELS);
            log_channel_num = log2_t'($clog2(MODE1_CHANNELS));
        end
    end

    assign ch_step  = signal_add;
    assign of_base  = of_counter - 16'd1;
    assign ch_total = of_base + channel_counter;

    // channel loop ends at group size or at the last channel of the tile
    assign ch_last = ch_step && ((ch_total == cur_pof) || (channel_counter == channel_num));
    assign of_last = ch_step && (ch_total == cur_pof);
    assign oy_last = of_last && (oy_counter == cur_poy);

    always_ff @(posedge clk) begin
        if (reset) begin
            signal_add <= 1'b0;
        end else if (quantify_add_end) begin
            signal_add <= 1'b1;
        end else if (oy_last) begin
            signal_add <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            channel_counter <= 16'd1;
            of_counter      <= 16'd1;
            oy_counter      <= 16'd1;
        end else begin
            if (ch_step) begin
                channel_counter <= ch_last ? 16'd1 : channel_counter + 16'd1;
            end
            if (ch_last) begin
                of_counter <= of_last ? 16'd1 : of_counter + channel_num;
            end
            if (of_last) begin
                oy_counter <= oy_last ? 16'd1 : oy_counter + 16'd1;
            end
        end
    end

    //////////////////////////////////////////////////
    // fifo read strobes
    //////////////////////////////////////////////////

    assign of_group = of_base >> log_channel_num;
    assign oy_group = oy_counter - 16'd1;

    // mode 1 reads one entry per two channels
    assign rd_strobe = ch_step && ((mode == 1'b0) || channel_counter[0]);

    always_comb begin
        for (int i = 0; i < FIFO_NUM; i++) begin
            fifo_rds[i] = rd_strobe && ((oy_group * SA_ROW_NUM + of_group) == i);
        end
    end

    //////////////////////////////////////////////////
    // cycle 1 outputs
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_rowi_out_buf_adr <= 1'b0;
            conv_out_add_end       <= 1'b0;
            out_upper              <= 1'b0;
            fifo_column_no         <= '0;
            fifo_row_no            <= '0;
        end else begin
            valid_rowi_out_buf_adr <= ch_step;
            conv_out_add_end       <= oy_last;
            // odd count means a fresh entry
            out_upper              <= channel_counter[0];
            fifo_column_no         <= grid_t'(oy_group);
            fifo_row_no            <= grid_t'(of_group);
        end
    end

    always_ff @(posedge clk) begin
        out_y_idx <= cur_oy_start - 16'd1 + oy_counter;
        out_x_idx <= cur_ox_start;
        out_f_idx <= cur_of_start - 16'd2 + of_counter + channel_counter;
    end

    assign lo_half = fifo_data[out_width-1:0];
    assign hi_half = fifo_data[row_width-1:out_width];

    // mode 1: upper half on the read cycle, lower half from the held entry after
    always_comb begin
        if (!valid_rowi_out_buf_adr) begin
            out_data = '0;
        end else if ((mode == 1'b1) && out_upper) begin
            out_data = hi_half;
        end else begin
            out_data = lo_half;
        end
    end

endmodule

`default_nettype wire

// File: verilog/out_buf_writer.sv
`default_nettype none
`timescale 1ns/100ps

module out_buf_writer
    import conv_out_pkg::*;
#(
    parameter int column_num    = 4,
    parameter int buf_adr_width = 10
) (
    input  wire                       clk,
    input  wire                       reset,
    input  wire log2_t                of_in_2pow,
    input  wire log2_t                ox_in_2pow,
    input  wire                       valid,
    input  wire idx_t                 y_idx,
    input  wire idx_t                 x_idx,
    input  wire idx_t                 f_idx,
    input  wire [16*column_num-1:0]   data,
    input  wire                       rd_en,
    input  wire [buf_adr_width-1:0]   rd_adr,
    output logic [16*column_num-1:0]  rd_data
);

    localparam int out_width = 16 * column_num;
    localparam int buf_depth = 1 << buf_adr_width;

    logic [out_width-1:0]     mem [buf_depth];
    logic [31:0]              yx_adr;
    logic [31:0]              full_adr;
    logic [buf_adr_width-1:0] wr_adr;

    //////////////////////////////////////////////////
    // address from y, x, f
    //////////////////////////////////////////////////

    assign yx_adr   = ({16'd0, y_idx} << ox_in_2pow) + {16'd0, x_idx};
    assign full_adr = (yx_adr << of_in_2pow) + {16'd0, f_idx};

    // wraps within the buffer
    assign wr_adr = full_adr[buf_adr_width-1:0];

    always_ff @(posedge clk) begin
        if (valid) begin
            mem[wr_adr] <= data;
        end
    end

    //////////////////////////////////////////////////
    // host read port
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_adr];
        end
    end

endmodule

`default_nettype wire

// File: verilog/conv_out_top.sv
`default_nettype none
`timescale 1ns/100ps

module conv_out_top
    import conv_out_pkg::*;
#(
    parameter int column_num    = 4,
    parameter int fifo_depth    = 16,
    parameter int buf_adr_width = 10
) (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       mode,
    input  wire                       quantify_en,
    input  wire [64*column_num-1:0]   psum_row,
    input  wire log2_t                quant_shift,
    input  wire [3:0]                 fifo_sel,
    input  wire                       quantify_add_end,
    input  wire idx_t                 cur_ox_start,
    input  wire idx_t                 cur_oy_start,
    input  wire idx_t                 cur_of_start,
    input  wire idx_t                 cur_pof,
    input  wire idx_t                 cur_poy,
    input  wire log2_t                of_in_2pow,
    input  wire log2_t                ox_in_2pow,
    input  wire                       rd_en,
    input  wire [buf_adr_width-1:0]   rd_adr,
    output logic [16*column_num-1:0]  rd_data,
    output logic                      conv_out_add_end
);

    localparam int row_width = 32 * column_num;
    localparam int out_width = 16 * column_num;

    logic [FIFO_NUM-1:0]  fifo_wr_en;
    logic [row_width-1:0] fifo_wr_data;
    logic [FIFO_NUM-1:0]  fifo_rds;
    logic [row_width-1:0] fifo_rd_data [FIFO_NUM];
    logic [FIFO_NUM-1:0]  fifo_empty;
    logic [row_width-1:0] fifo_data;
    grid_t                fifo_column_no;
    grid_t                fifo_row_no;
    logic [7:0]           fifo_idx;

    logic                 out_valid;
    idx_t                 out_y_idx;
    idx_t                 out_x_idx;
    idx_t                 out_f_idx;
    logic [out_width-1:0] out_data;

    row_quantizer #(
        .column_num (column_num)
    ) u_quantizer (
        .clk         (clk),
        .reset       (reset),
        .quantify_en (quantify_en),
        .psum_row    (psum_row),
        .quant_shift (quant_shift),
        .fifo_sel    (fifo_sel),
        .wr_en       (fifo_wr_en),
        .wr_data     (fifo_wr_data)
    );

    //////////////////////////////////////////////////
    // row fifos, one per array
    //////////////////////////////////////////////////

    for (genvar i = 0; i < FIFO_NUM; i++) begin : g_fifo
        row_fifo #(
            .column_num (column_num),
            .fifo_depth (fifo_depth)
        ) u_fifo (
            .clk     (clk),
            .reset   (reset),
            .wr_en   (fifo_wr_en[i]),
            .wr_data (fifo_wr_data),
            .rd_en   (fifo_rds[i]),
            .rd_data (fifo_rd_data[i]),
            .empty   (fifo_empty[i])
        );
    end

    // read data mux, selected by the registered grid position
    assign fifo_idx = 8'(fifo_column_no * SA_ROW_NUM + fifo_row_no);

    always_comb begin
        fifo_data = '0;
        for (int i = 0; i < FIFO_NUM; i++) begin
            if (fifo_idx == i) begin
                fifo_data = fifo_rd_data[i];
            end
        end
    end

    conv_out_handler #(
        .column_num (column_num)
    ) u_handler (
        .clk                    (clk),
        .reset                  (reset),
        .mode                   (mode),
        .cur_ox_start           (cur_ox_start),
        .cur_oy_start           (cur_oy_start),
        .cur_of_start           (cur_of_start),
        .cur_pof                (cur_pof),
        .cur_poy                (cur_poy),
        .quantify_add_end       (quantify_add_end),
        .fifo_rds               (fifo_rds),
        .fifo_data              (fifo_data),
        .fifo_column_no         (fifo_column_no),
        .fifo_row_no            (fifo_row_no),
        .valid_rowi_out_buf_adr (out_valid),
        .out_y_idx              (out_y_idx),
        .out_x_idx              (out_x_idx),
        .out_f_idx              (out_f_idx),
        .out_data               (out_data),
        .conv_out_add_end       (conv_out_add_end)
    );

    out_buf_writer #(
        .column_num    (column_num),
        .buf_adr_width (buf_adr_width)
    ) u_buf_writer (
        .clk        (clk),
        .reset      (reset),
        .of_in_2pow (of_in_2pow),
        .ox_in_2pow (ox_in_2pow),
        .valid      (out_valid),
        .y_idx      (out_y_idx),
        .x_idx      (out_x_idx),
        .f_idx      (out_f_idx),
        .data       (out_data),
        .rd_en      (rd_en),
        .rd_adr     (rd_adr),
        .rd_data    (rd_data)
    );

endmodule

`default_nettype wire

// File: sim/conv_out_tb.sv
`default_nettype none
`timescale 1ns/100ps

module conv_out_tb
    import conv_out_pkg::*;
();

    localparam int column_num    = 4;
    localparam int buf_adr_width = 10;
    localparam int psum_width    = 64 * column_num;
    localparam int out_width     = 16 * column_num;
    localparam tests_file        = "sim/conv_out_tests.txt";

    logic                     clk;
    logic                     reset;
    logic                     mode;
    logic                     quantify_en;
    logic [psum_width-1:0]    psum_row;
    log2_t                    quant_shift;
    logic [3:0]               fifo_sel;
    logic                     quantify_add_end;
    idx_t                     cur_ox_start;
    idx_t                     cur_oy_start;
    idx_t                     cur_of_start;
    idx_t                     cur_pof;
    idx_t                     cur_poy;
    log2_t                    of_in_2pow;
    log2_t                    ox_in_2pow;
    logic                     rd_en;
    logic [buf_adr_width-1:0] rd_adr;
    logic [out_width-1:0]     rd_data;
    logic                     conv_out_add_end;

    int cycle_count = 0;
    int cycle_limit = 0;
    int tiles_run   = 0;
    int checks_run  = 0;

    conv_out_top #(
        .column_num    (column_num),
        .fifo_depth    (16),
        .buf_adr_width (buf_adr_width)
    ) uut (
        .clk              (clk),
        .reset            (reset),
        .mode             (mode),
        .quantify_en      (quantify_en),
        .psum_row         (psum_row),
        .quant_shift      (quant_shift),
        .fifo_sel         (fifo_sel),
        .quantify_add_end (quantify_add_end),
        .cur_ox_start     (cur_ox_start),
        .cur_oy_start     (cur_oy_start),
        .cur_of_start     (cur_of_start),
        .cur_pof          (cur_pof),
        .cur_poy          (cur_poy),
        .of_in_2pow       (of_in_2pow),
        .ox_in_2pow       (ox_in_2pow),
        .rd_en            (rd_en),
        .rd_adr           (rd_adr),
        .rd_data          (rd_data),
        .conv_out_add_end (conv_out_add_end)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // watchdog limit set once the tests file is scanned
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("run did not finish within %0d cycles", cycle_limit);
            stop_run();
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    task automatic stop_run();
        $display("Testbench failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input int adr, input logic [out_width-1:0] expected,
                              input logic [out_width-1:0] actual);
        if (actual !== expected) begin
            $display("ERR rd_data adr %0h expected %h actual %h", adr, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_done(input int tile, input int pulses);
        if (pulses == 0) begin
            $display("tile %0d never raised conv_out_add_end", tile);
            stop_run();
        end else if (pulses != 1) begin
            $display("tile %0d raised conv_out_add_end %0d times", tile, pulses);
            stop_run();
        end
    endtask

    // every row fifo drained once the tile is done
    task automatic check_fifos_empty(input int tile);
        if (uut.fifo_empty !== {FIFO_NUM{1'b1}}) begin
            $display("tile %0d left entries in the row fifos, empty flags %h",
                     tile, uut.fifo_empty);
            stop_run();
        end
    endtask

    task automatic check_fields(input int code, input int want);
        if (code != want) begin
            $display("malformed record in %s", tests_file);
            stop_run();
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    task automatic write_rows(input int sel, input int shift, input int count,
                              input logic [psum_width-1:0] row);
        int i;
        for (i = 0; i < count; i++) begin
            @(posedge clk);
            quantify_en <= 1'b1;
            psum_row    <= row;
            quant_shift <= log2_t'(shift);
            fifo_sel    <= 4'(sel);
        end
        @(posedge clk);
        quantify_en <= 1'b0;
    endtask

    task automatic start_tile();
        @(posedge clk);
        quantify_add_end <= 1'b1;
        @(posedge clk);
        quantify_add_end <= 1'b0;
    endtask

    // counts done pulses and keeps watching a few cycles after the first
    task automatic wait_tile_end(input int bound, output int pulses);
        int waited;
        int after;
        pulses = 0;
        waited = 0;
        after  = 0;
        while (waited < bound && after < 8) begin
            @(posedge clk);
            waited++;
            if (conv_out_add_end === 1'b1) begin
                pulses++;
            end
            if (pulses > 0) begin
                after++;
            end
        end
    endtask

    task automatic read_word(input int adr, output logic [out_width-1:0] data);
        @(posedge clk);
        rd_en  <= 1'b1;
        rd_adr <= buf_adr_width'(adr);
        @(posedge clk);
        rd_en  <= 1'b0;
        @(posedge clk);
        data = rd_data;
    endtask

    // total output cycles over all tiles
    task automatic sum_tile_work(output int work);
        int fd;
        int code;
        int skip;
        int pof;
        int poy;
        logic [63:0] kw;
        logic [8*256-1:0] rest;
        work = 0;
        fd = $fopen(tests_file, "r");
        if (fd == 0) begin
            $display("could not open %s", tests_file);
            stop_run();
        end
        code = $fscanf(fd, "%s", kw);
        while (code == 1) begin
            if (kw == "tile") begin
                code = $fscanf(fd, "%d %d %d", skip, pof, poy);
                work = work + pof * poy;
            end
            code = $fgets(rest, fd);
            code = $fscanf(fd, "%s", kw);
        end
        $fclose(fd);
    endtask

    //////////////////////////////////////////////////
    // main flow
    //////////////////////////////////////////////////

    initial begin : main_flow
        int fd;
        int code;
        int work;
        int pulses;
        int tile_work;
        int i;
        int t_mode;
        int t_pof;
        int t_poy;
        int t_ox;
        int t_oy;
        int t_of;
        int t_of2;
        int t_ox2;
        int r_sel;
        int r_shift;
        int r_count;
        int e_adr;
        int e_count;
        int e_stride;
        bit finished;
        logic [63:0] kw;
        logic [psum_width-1:0] row;
        logic [out_width-1:0] word;
        logic [out_width-1:0] got;
        logic [8*256-1:0] rest;

        reset            = 1'b1;
        mode             = 1'b0;
        quantify_en      = 1'b0;
        psum_row         = '0;
        quant_shift      = '0;
        fifo_sel         = '0;
        quantify_add_end = 1'b0;
        cur_ox_start     = '0;
        cur_oy_start     = '0;
        cur_of_start     = '0;
        cur_pof          = '0;
        cur_poy          = '0;
        of_in_2pow       = '0;
        ox_in_2pow       = '0;
        rd_en            = 1'b0;
        rd_adr           = '0;
        tile_work        = 0;

        sum_tile_work(work);
        cycle_limit = 20 * work + 2000;

        repeat (8) @(posedge clk);
        reset <= 1'b0;

        fd = $fopen(tests_file, "r");
        if (fd == 0) begin
            $display("could not open %s", tests_file);
            stop_run();
        end
        finished = 1'b0;
        while (!finished) begin
            code = $fscanf(fd, "%s", kw);
            if (code != 1) begin
                finished = 1'b1;
            end else if (kw == "#") begin
                code = $fgets(rest, fd);
            end else if (kw == "tile") begin
                code = $fscanf(fd, "%d %d %d %d %d %d %d %d",
                               t_mode, t_pof, t_poy, t_ox, t_oy, t_of, t_of2, t_ox2);
                check_fields(code, 8);
                tile_work = t_pof * t_poy;
                // held until the tile is read back
                @(posedge clk);
                mode         <= t_mode[0];
                cur_pof      <= idx_t'(t_pof);
                cur_poy      <= idx_t'(t_poy);
                cur_ox_start <= idx_t'(t_ox);
                cur_oy_start <= idx_t'(t_oy);
                cur_of_start <= idx_t'(t_of);
                of_in_2pow   <= log2_t'(t_of2);
                ox_in_2pow   <= log2_t'(t_ox2);
            end else if (kw == "row") begin
                code = $fscanf(fd, "%d %d %d %h", r_sel, r_shift, r_count, row);
                check_fields(code, 4);
                write_rows(r_sel, r_shift, r_count, row);
            end else if (kw == "run") begin
                start_tile();
                wait_tile_end(tile_work * 4 + 100, pulses);
                check_done(tiles_run, pulses);
                check_fifos_empty(tiles_run);
                tiles_run++;
            end else if (kw == "exp") begin
                code = $fscanf(fd, "%d %d %d %h", e_adr, e_count, e_stride, word);
                check_fields(code, 4);
                for (i = 0; i < e_count; i++) begin
                    read_word(e_adr + i * e_stride, got);
                    check_word(e_adr + i * e_stride, word, got);
                    checks_run++;
                end
            end else begin
                $display("unknown record type in %s", tests_file);
                stop_run();
            end
        end
        $fclose(fd);

        if (tiles_run == 0 || checks_run == 0) begin
            $display("tests file held no tile with expected words");
            stop_run();
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sim.f
verilog/conv_out_pkg.sv
verilog/row_fifo.sv
verilog/row_quantizer.sv
verilog/conv_out_handler.sv
verilog/out_buf_writer.sv
verilog/conv_out_top.sv
sim/conv_out_tb.sv

// File: sim/conv_out_tests.txt
# tile mode pof poy ox_start oy_start of_start of_in_2pow ox_in_2pow
# row fifo_sel quant_shift count psum_hex, then run, then exp adr count stride word_hex
# mode 0, two rows of 16 channels, saturation at shifts 0 4 8 2 1
tile 0 16 2 0 0 0 4 0
row 0 0 1 00050005000500050005000500050005000080007FFFFF7FFF800080007F0001
row 0 4 7 000000000000000000000000000000000017FFF0FFFFF7F0F800080007F00100
row 0 8 8 00010001000100010001000100010001C0004000FF0000FFEDCC80007FFF1234
row 4 2 3 00000000000000000000000000000000FDFC020001FCFFFC0010000C00080004
row 4 1 13 00000000000000000000000000000000010000EE00CC00AA0088006600440022
run
exp 0 1 1 00807F80807F7F01
exp 1 7 1 01FFFF80807F7F10
exp 8 8 1 C040FF00ED807F12
exp 16 3 1 807F7FFF04030201
exp 19 13 1 7F77665544332211
# mode 1, 32 channels from one fifo, tile origin moved to y 2 x 1
tile 1 32 1 1 2 0 5 1
row 0 0 1 0078007700760075007400730072007100080007000600050004000300020001
row 0 3 15 FFF0FFF0FFF0FFF0FFF0FFF0FFF0FFF000080008000800080008000800080008
run
exp 160 1 1 7877767574737271
exp 161 1 1 0807060504030201
exp 162 15 2 FEFEFEFEFEFEFEFE
exp 163 15 2 0101010101010101
# partial group of 5 channels over the second row of the first tile
tile 0 5 1 0 1 3 4 0
row 0 5 5 000000000000000000000000000000000060FFE0EFE0F00010000FE000400020
run
exp 18 1 1 807F7FFF04030201
exp 19 5 1 03FF80807F7F0201
exp 24 1 1 7F77665544332211
